// ==== fft_pkg.sv ====
package fft_pkg;

	////////////////////
	// transform size
	////////////////////

	// the twiddle rom is written out for exactly this size
	localparam int N_POINTS    = 8;
	localparam int LOG2_POINTS = 3;

	////////////////////
	// number formats
	////////////////////

	// signed 2.16 fixed point
	typedef logic signed [17:0] sample_t;

	// re sits in the upper half of the packed word
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	typedef logic [2:0] addr_t;
	typedef logic [1:0] tw_idx_t;

	// wishbone word and word address
	typedef logic [31:0] wb_data_t;
	typedef logic [4:0]  wb_addr_t;

	// one butterfly as issued by the sequencer
	typedef struct packed {
		cplx_t top;
		cplx_t bot;
		addr_t top_addr;
		addr_t bot_addr;
	} bfly_op_t;

	// both results with the addresses they go back to
	typedef struct packed {
		cplx_t x;
		cplx_t y;
		addr_t x_addr;
		addr_t y_addr;
	} bfly_res_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN,
		FINISH
	} ctrl_state_t;

	////////////////////
	// address map
	////////////////////

	// 0..7 real parts, 8..15 imaginary parts
	localparam wb_addr_t ADR_RE_BASE = 5'd0;
	localparam wb_addr_t ADR_IM_BASE = 5'd8;
	// bit 0 start
	localparam wb_addr_t ADR_CTRL    = 5'd16;
	// bit 0 busy, bit 1 done
	localparam wb_addr_t ADR_STATUS  = 5'd17;

endpackage

// ==== complex_mult.sv ====
`timescale 1ns/100ps

module complex_mult (
	input  logic          clk,
	input  fft_pkg::cplx_t b,
	input  fft_pkg::cplx_t w,
	output fft_pkg::cplx_t p
);
	import fft_pkg::*;

	// 2.16 times 2.16, keeps sign bit and bits 32:16 of the full product
	function automatic sample_t mult_2_16(input sample_t x, input sample_t y);
		logic signed [35:0] full;
		full = x * y;
		return {full[35], full[32:16]};
	endfunction

	// the four partial products
	sample_t rr;
	sample_t ii;
	sample_t ri;
	sample_t ir;

	// one guard bit before halving
	logic signed [18:0] sum_re;
	logic signed [18:0] sum_im;

	always_comb begin
		rr = mult_2_16(b.re, w.re);
		ii = mult_2_16(b.im, w.im);
		ri = mult_2_16(b.re, w.im);
		ir = mult_2_16(b.im, w.re);
		// (br + j bi)(wr + j wi)
		sum_re = rr - ii;
		sum_im = ri + ir;
	end

	// drop the lowest bit, so the product comes out halved
	always_ff @(posedge clk) begin
		p.re <= sum_re[18:1];
		p.im <= sum_im[18:1];
	end

endmodule

// ==== butterfly.sv ====
`timescale 1ns/100ps

module butterfly (
	input  logic              clk,
	input  logic              rst,
	input  logic              op_valid,
	input  fft_pkg::bfly_op_t  op,
	input  fft_pkg::cplx_t     w,
	output logic              res_valid,
	output fft_pkg::bfly_res_t res
);
	import fft_pkg::*;

	// product of bot and twiddle, already halved
	cplx_t p;

	// first stage copies, aligned with p
	cplx_t top_d;
	addr_t top_addr_d;
	addr_t bot_addr_d;
	logic  valid_d;

	// top scaled by one half
	cplx_t top_half;

	complex_mult i_cmul (
		.clk (clk),
		.b   (op.bot),
		.w   (w),
		.p   (p)
	);

	////////////////////
	// stage 1
	////////////////////

	always_ff @(posedge clk) begin
		top_d      <= op.top;
		top_addr_d <= op.top_addr;
		bot_addr_d <= op.bot_addr;
	end

	////////////////////
	// stage 2
	////////////////////

	always_comb begin
		top_half.re = top_d.re >>> 1;
		top_half.im = top_d.im >>> 1;
	end

	// sum and difference wrap at 18 bits
	always_ff @(posedge clk) begin
		res.x.re <= top_half.re + p.re;
		res.x.im <= top_half.im + p.im;
		res.y.re <= top_half.re - p.re;
		res.y.im <= top_half.im - p.im;
		res.x_addr <= top_addr_d;
		res.y_addr <= bot_addr_d;
	end

	// valid follows the data two cycles behind op_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_d   <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			valid_d   <= op_valid;
			res_valid <= valid_d;
		end
	end

endmodule

// ==== twiddle_rom.sv ====
`timescale 1ns/100ps

module twiddle_rom (
	input  fft_pkg::tw_idx_t idx,
	output fft_pkg::cplx_t   w
);
	import fft_pkg::*;

	// W_k = cos(2 pi k/8) - j sin(2 pi k/8), rounded to 2.16
	// 46341 is 1/sqrt(2) in 2.16
	always_comb begin
		unique case (idx)
			2'd0: begin
				w.re = 18'sd65536;
				w.im = 18'sd0;
			end
			2'd1: begin
				w.re = 18'sd46341;
				w.im = -18'sd46341;
			end
			2'd2: begin
				w.re = 18'sd0;
				w.im = -18'sd65536;
			end
			2'd3: begin
				w.re = -18'sd46341;
				w.im = -18'sd46341;
			end
		endcase
	end

endmodule

// ==== sample_ram.sv ====
`timescale 1ns/100ps

module sample_ram (
	input  logic           clk,
	input  logic           rst,
	// read ports, asynchronous
	input  fft_pkg::addr_t rd_addr0,
	input  fft_pkg::addr_t rd_addr1,
	output fft_pkg::cplx_t rd_data0,
	output fft_pkg::cplx_t rd_data1,
	// write ports, synchronous
	input  logic           we0,
	input  logic           we1,
	input  fft_pkg::addr_t wr_addr0,
	input  fft_pkg::addr_t wr_addr1,
	input  fft_pkg::cplx_t wr_data0,
	input  fft_pkg::cplx_t wr_data1
);
	import fft_pkg::*;

	// one complex word per point
	cplx_t mem [N_POINTS];

	////////////////////
	// reads
	////////////////////

	assign rd_data0 = mem[rd_addr0];
	assign rd_data1 = mem[rd_addr1];

	////////////////////
	// writes
	////////////////////

	// samples read back as zero until the host loads them
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_POINTS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (we1) begin
				mem[wr_addr1] <= wr_data1;
			end
			// port 0 comes last, so it wins on a collision
			if (we0) begin
				mem[wr_addr0] <= wr_data0;
			end
		end
	end

endmodule

// ==== fft_ctrl.sv ====
`timescale 1ns/100ps

module fft_ctrl (
	input  logic               clk,
	input  logic               rst,
	// wishbone classic slave
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  fft_pkg::wb_addr_t   adr,
	input  fft_pkg::wb_data_t   dat_w,
	output logic               ack,
	output fft_pkg::wb_data_t   dat_r,
	// sample ram
	output fft_pkg::addr_t      rd_addr0,
	output fft_pkg::addr_t      rd_addr1,
	output logic               we0,
	output logic               we1,
	output fft_pkg::addr_t      wr_addr0,
	output fft_pkg::addr_t      wr_addr1,
	output fft_pkg::cplx_t      wr_data0,
	output fft_pkg::cplx_t      wr_data1,
	input  fft_pkg::cplx_t      rd_data0,
	input  fft_pkg::cplx_t      rd_data1,
	// butterfly datapath
	output logic               op_valid,
	output fft_pkg::bfly_op_t   op,
	output fft_pkg::tw_idx_t    tw_idx,
	input  logic               res_valid,
	input  fft_pkg::bfly_res_t  res
);
	import fft_pkg::*;

	localparam logic [1:0] LAST_STAGE = 2'(LOG2_POINTS - 1);
	localparam logic [1:0] BFLY_LAST  = 2'(N_POINTS / 2 - 1);

	ctrl_state_t state;
	logic [1:0]  stage;
	logic [1:0]  bfly;
	logic        drain_cnt;
	logic        busy;
	logic        done;

	// bus decode
	logic        acc;
	logic        is_re;
	logic        is_im;
	logic        host_wr;
	logic        start_hit;
	addr_t       host_idx;
	addr_t       host_rd_addr;
	cplx_t       host_word;
	wb_data_t    rd_word;

	// butterfly addressing
	addr_t       half;
	addr_t       grp;
	addr_t       ofs;
	addr_t       top_addr;
	addr_t       bot_addr;

	////////////////////
	// wishbone
	////////////////////

	// a fresh request is one that is not being acked right now
	assign acc       = cyc & stb & ~ack;
	assign is_re     = (adr[4:3] == ADR_RE_BASE[4:3]);
	assign is_im     = (adr[4:3] == ADR_IM_BASE[4:3]);
	// sample and start writes are dropped while a transform runs
	assign host_wr   = acc & we & (is_re | is_im) & ~busy;
	assign start_hit = acc & we & (adr == ADR_CTRL) & dat_w[0] & ~busy;

	// writes land bit-reversed, reads use the natural order
	assign host_idx     = adr[2:0];
	assign host_rd_addr = we ? {host_idx[0], host_idx[1], host_idx[2]} : host_idx;

	// keep the half that is not written
	always_comb begin
		host_word = rd_data0;
		if (is_re) begin
			host_word.re = sample_t'(dat_w[17:0]);
		end else begin
			host_word.im = sample_t'(dat_w[17:0]);
		end
	end

	// read mux, samples sign-extended
	always_comb begin
		rd_word = '0;
		if (is_re && !busy) begin
			rd_word = {{14{rd_data0.re[17]}}, rd_data0.re};
		end else if (is_im && !busy) begin
			rd_word = {{14{rd_data0.im[17]}}, rd_data0.im};
		end else if (adr == ADR_STATUS) begin
			rd_word = {30'd0, done, busy};
		end
	end

	// one-cycle ack, then wait for stb to drop
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= acc;
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			dat_r <= rd_word;
		end
	end

	////////////////////
	// addresses
	////////////////////

	// group and offset within the stage, half-span is 2^stage
	always_comb begin
		half     = addr_t'(1) << stage;
		grp      = addr_t'(bfly) >> stage;
		ofs      = addr_t'(bfly) & (half - addr_t'(1));
		top_addr = (grp << (stage + 1)) + ofs;
		bot_addr = top_addr + half;
		tw_idx   = tw_idx_t'({ofs, 2'b00} >> stage);
	end

	////////////////////
	// ram ports
	////////////////////

	// host owns port 0 while idle
	assign rd_addr0 = busy ? top_addr : host_rd_addr;
	assign rd_addr1 = bot_addr;

	assign we0      = host_wr | res_valid;
	assign wr_addr0 = busy ? res.x_addr : host_rd_addr;
	assign wr_data0 = busy ? res.x : host_word;
	assign we1      = res_valid;
	assign wr_addr1 = res.y_addr;
	assign wr_data1 = res.y;

	assign op_valid    = (state == RUN);
	assign op.top      = rd_data0;
	assign op.bot      = rd_data1;
	assign op.top_addr = top_addr;
	assign op.bot_addr = bot_addr;

	////////////////////
	// sequencer
	////////////////////

	// 4 issue + 2 drain cycles per stage
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			stage     <= '0;
			bfly      <= '0;
			drain_cnt <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start_hit) begin
						state <= RUN;
						stage <= '0;
						bfly  <= '0;
						busy  <= 1'b1;
						done  <= 1'b0;
					end
				end
				RUN: begin
					// wraps back to 0 for the next stage
					bfly <= bfly + 2'd1;
					if (bfly == BFLY_LAST) begin
						state     <= DRAIN;
						drain_cnt <= 1'b0;
					end
				end
				DRAIN: begin
					drain_cnt <= ~drain_cnt;
					// last write-back of the stage lands this cycle
					if (drain_cnt) begin
						if (stage == LAST_STAGE) begin
							state <= FINISH;
						end else begin
							stage <= stage + 2'd1;
							state <= RUN;
						end
					end
				end
				FINISH: begin
					busy  <= 1'b0;
					done  <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== fft_top.sv ====
`timescale 1ns/100ps

module fft_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  fft_pkg::wb_addr_t adr,
	input  fft_pkg::wb_data_t dat_w,
	output logic             ack,
	output fft_pkg::wb_data_t dat_r
);
	import fft_pkg::*;

	////////////////////
	// ram side
	////////////////////

	addr_t rd_addr0;
	addr_t rd_addr1;
	cplx_t rd_data0;
	cplx_t rd_data1;
	logic  we0;
	logic  we1;
	addr_t wr_addr0;
	addr_t wr_addr1;
	cplx_t wr_data0;
	cplx_t wr_data1;

	////////////////////
	// datapath side
	////////////////////

	logic      op_valid;
	bfly_op_t  op;
	tw_idx_t   tw_idx;
	cplx_t     w;
	logic      res_valid;
	bfly_res_t res;

	fft_ctrl i_ctrl (
		.clk       (clk),
		.rst       (rst),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.ack       (ack),
		.dat_r     (dat_r),
		.rd_addr0  (rd_addr0),
		.rd_addr1  (rd_addr1),
		.we0       (we0),
		.we1       (we1),
		.wr_addr0  (wr_addr0),
		.wr_addr1  (wr_addr1),
		.wr_data0  (wr_data0),
		.wr_data1  (wr_data1),
		.rd_data0  (rd_data0),
		.rd_data1  (rd_data1),
		.op_valid  (op_valid),
		.op        (op),
		.tw_idx    (tw_idx),
		.res_valid (res_valid),
		.res       (res)
	);

	sample_ram i_ram (
		.clk      (clk),
		.rst      (rst),
		.rd_addr0 (rd_addr0),
		.rd_addr1 (rd_addr1),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1),
		.we0      (we0),
		.we1      (we1),
		.wr_addr0 (wr_addr0),
		.wr_addr1 (wr_addr1),
		.wr_data0 (wr_data0),
		.wr_data1 (wr_data1)
	);

	// twiddle is looked up in the issue cycle
	twiddle_rom i_rom (
		.idx (tw_idx),
		.w   (w)
	);

	butterfly i_bfly (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.op        (op),
		.w         (w),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
	output logic clk,
	output logic rst
);
	localparam int RESET_CYCLES = 10;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// released on a rising edge, like the rest of the stimulus
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== fft_sva.sv ====
`timescale 1ns/100ps

module fft_sva (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic busy,
	input logic done
);
	// number of assertion failures so far
	int unsigned fail_cnt = 0;

	////////////////////
	// wishbone
	////////////////////

	// ack answers a request seen one cycle earlier
	ack_after_req: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cyc && stb))
		else begin
			$error("ack without cyc and stb in the previous cycle");
			fail_cnt++;
		end

	// single-cycle ack pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		ack |=> !ack)
		else begin
			$error("ack held high for two cycles");
			fail_cnt++;
		end

	////////////////////
	// control flags
	////////////////////

	busy_done_excl: assert property (@(posedge clk) disable iff (rst)
		!(busy && done))
		else begin
			$error("busy and done set together");
			fail_cnt++;
		end

	// state left by a reset edge
	reset_quiet: assert property (@(posedge clk)
		$past(rst) |-> (!ack && !busy && !done))
		else begin
			$error("ack, busy or done high during reset");
			fail_cnt++;
		end

endmodule

// flags live inside the controller
bind fft_top fft_sva i_sva (
	.clk  (clk),
	.rst  (rst),
	.cyc  (cyc),
	.stb  (stb),
	.ack  (ack),
	.busy (i_ctrl.busy),
	.done (i_ctrl.done)
);

// ==== fft_tb.sv ====
`timescale 1ns/100ps

module fft_tb;
	import fft_pkg::*;

	localparam int unsigned SEED = 32'h4148_f192;
	// about twice what 24 transforms and their bus traffic need
	localparam int MAX_CYCLES = 6000;

	// twiddle table W0..W3 in 2.16
	localparam sample_t TW_RE [4] = '{18'sd65536, 18'sd46341, 18'sd0, -18'sd46341};
	localparam sample_t TW_IM [4] = '{18'sd0, -18'sd46341, -18'sd65536, -18'sd46341};

	logic     clk;
	logic     rst;
	logic     cyc;
	logic     stb;
	logic     we;
	wb_addr_t adr;
	wb_data_t dat_w;
	logic     ack;
	wb_data_t dat_r;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// input in natural order and the expected spectrum
	sample_t in_re [8];
	sample_t in_im [8];
	sample_t exp_re [8];
	sample_t exp_im [8];

	tb_clkgen i_clkgen (
		.clk (clk),
		.rst (rst)
	);

	fft_top i_dut (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.ack   (ack),
		.dat_r (dat_r)
	);

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: transform never finished");
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////
	// helpers
	////////////////////

	function automatic wb_data_t widen(input sample_t v);
		return {{14{v[17]}}, v};
	endfunction

	function automatic addr_t rev3(input addr_t i);
		return {i[0], i[1], i[2]};
	endfunction

	// magnitude below 0.9 in 2.16
	function automatic sample_t rand_sample();
		return sample_t'(int'($urandom_range(117962)) - 58981);
	endfunction

	// 2.16 product, sign bit then bits 32:16
	function automatic sample_t prod(input sample_t x, input sample_t y);
		logic signed [35:0] full;
		full = x * y;
		return {full[35], full[32:16]};
	endfunction

	////////////////////
	// bus access
	////////////////////

	task automatic wait_ack;
		do begin
			@(posedge clk);
		end while (ack !== 1'b1);
	endtask

	task automatic bus_write(input wb_addr_t a, input wb_data_t d);
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= 1'b1;
		adr   <= a;
		dat_w <= d;
		wait_ack();
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic bus_read(input wb_addr_t a, output wb_data_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we  <= 1'b0;
		adr <= a;
		wait_ack();
		d = dat_r;
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	task automatic check_word(input wb_addr_t a, input wb_data_t expected);
		wb_data_t got;
		bus_read(a, got);
		checks++;
		assert (got === expected)
		else begin
			$display("error: %0t ns adr %0d expected %08h got %08h", $time, a, expected, got);
			errors++;
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	// in-place DIT over bit-reversed input, each stage scales by one half
	task automatic run_model;
		sample_t ar [8];
		sample_t ai [8];
		sample_t pr;
		sample_t pi;
		sample_t hr;
		sample_t hi;
		logic signed [18:0] sr;
		logic signed [18:0] si;
		int span;
		int t;
		int b;
		int k;
		for (int i = 0; i < 8; i++) begin
			ar[rev3(i)] = in_re[i];
			ai[rev3(i)] = in_im[i];
		end
		for (int s = 0; s < 3; s++) begin
			span = 1 << s;
			for (int g = 0; g < 8; g += 2 * span) begin
				for (int j = 0; j < span; j++) begin
					t = g + j;
					b = t + span;
					k = (j * 4) >> s;
					// bot times twiddle, halved
					sr = prod(ar[b], TW_RE[k]) - prod(ai[b], TW_IM[k]);
					si = prod(ar[b], TW_IM[k]) + prod(ai[b], TW_RE[k]);
					pr = sr[18:1];
					pi = si[18:1];
					hr = ar[t] >>> 1;
					hi = ai[t] >>> 1;
					ar[t] = hr + pr;
					ai[t] = hi + pi;
					ar[b] = hr - pr;
					ai[b] = hi - pi;
				end
			end
		end
		exp_re = ar;
		exp_im = ai;
	endtask

	////////////////////
	// transform steps
	////////////////////

	task automatic load_inputs;
		for (int i = 0; i < 8; i++) begin
			bus_write(ADR_RE_BASE + wb_addr_t'(i), widen(in_re[i]));
			bus_write(ADR_IM_BASE + wb_addr_t'(i), widen(in_im[i]));
		end
	endtask

	task automatic wait_done;
		wb_data_t st;
		do begin
			bus_read(ADR_STATUS, st);
		end while (st[1] !== 1'b1);
	endtask

	task automatic check_spectrum;
		run_model();
		for (int k = 0; k < 8; k++) begin
			check_word(ADR_RE_BASE + wb_addr_t'(k), widen(exp_re[k]));
			check_word(ADR_IM_BASE + wb_addr_t'(k), widen(exp_im[k]));
		end
	endtask

	task automatic fill_random;
		for (int i = 0; i < 8; i++) begin
			in_re[i] = rand_sample();
			in_im[i] = rand_sample();
		end
	endtask

	task automatic full_transform;
		load_inputs();
		bus_write(ADR_CTRL, 32'd1);
		wait_done();
		check_spectrum();
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		wb_data_t v [16];
		sample_t  amp;
		int       src;
		void'($urandom(SEED));
		cyc   <= 1'b0;
		stb   <= 1'b0;
		we    <= 1'b0;
		adr   <= '0;
		dat_w <= '0;
		wait (rst === 1'b0);

		// state after reset
		check_word(ADR_STATUS, 32'd0);
		for (int i = 0; i < 16; i++) begin
			check_word(wb_addr_t'(i), 32'd0);
		end

		// raw sample access, writes land bit-reversed, reads are natural
		for (int i = 0; i < 16; i++) begin
			v[i] = $urandom() & 32'h3_ffff;
			bus_write(wb_addr_t'(i), v[i]);
		end
		for (int i = 0; i < 16; i++) begin
			src = (i & 8) | int'(rev3(addr_t'(i)));
			check_word(wb_addr_t'(i), widen(v[src][17:0]));
		end
		for (int a = 18; a < 32; a++) begin
			check_word(wb_addr_t'(a), 32'd0);
		end

		// impulse at index 0 spreads A/8 into every bin
		amp = -18'sd40000;
		for (int i = 0; i < 8; i++) begin
			in_re[i] = '0;
			in_im[i] = '0;
		end
		in_re[0] = amp;
		load_inputs();
		bus_write(ADR_CTRL, 32'd1);
		wait_done();
		for (int k = 0; k < 8; k++) begin
			check_word(ADR_RE_BASE + wb_addr_t'(k), widen(amp >>> 3));
			check_word(ADR_IM_BASE + wb_addr_t'(k), 32'd0);
		end

		// constant input
		for (int i = 0; i < 8; i++) begin
			in_re[i] = 18'sd30000;
			in_im[i] = '0;
		end
		full_transform();

		// random transforms
		for (int n = 0; n < 20; n++) begin
			fill_random();
			full_transform();
		end

		// sample and start writes while busy are dropped
		fill_random();
		load_inputs();
		bus_write(ADR_CTRL, 32'd1);
		bus_write(ADR_RE_BASE, 32'h0_3039);
		bus_write(ADR_IM_BASE + 5'd3, 32'h3_f00d);
		bus_write(ADR_CTRL, 32'd1);
		check_word(ADR_STATUS, 32'd1);
		wait_done();
		check_word(ADR_STATUS, 32'd2);
		check_spectrum();

		// restart clears done and runs on new data
		fill_random();
		load_inputs();
		check_word(ADR_STATUS, 32'd2);
		bus_write(ADR_CTRL, 32'd1);
		check_word(ADR_STATUS, 32'd1);
		wait_done();
		check_spectrum();

		repeat (2) @(posedge clk);
		$display("checks %0d, compare errors %0d, assertion failures %0d",
			checks, errors, i_dut.i_sva.fail_cnt);
		if (errors == 0 && i_dut.i_sva.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
fft_pkg.sv
complex_mult.sv
butterfly.sv
twiddle_rom.sv
sample_ram.sv
fft_ctrl.sv
fft_top.sv
tb_clkgen.sv
fft_sva.sv
fft_tb.sv

// ==== Bender.yml ====
package:
  name: fft8_wb

sources:
  - fft_pkg.sv
  - complex_mult.sv
  - butterfly.sv
  - twiddle_rom.sv
  - sample_ram.sv
  - fft_ctrl.sv
  - fft_top.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - fft_sva.sv
      - fft_tb.sv
